/* src/cmac_mul_settings.svh */
// widths follow the radix-4 booth layout and are not free to change
// the axi-lite map holds one register, the mode, at offset 0
`ifndef CMAC_MUL_SETTINGS_SVH
`define CMAC_MUL_SETTINGS_SVH

// ==============================
// datapath
// ==============================
`define CMAC_OP_W        16     // full int16 operand
`define CMAC_LANE_W      8      // int8 lane
`define CMAC_LANES       2      // lanes per operand
`define CMAC_RES_W       32     // final product
`define CMAC_PP_W        24     // level-1 carry-save row
`define CMAC_BOOTH_GRP   8      // radix-4 digits, 4 per group

// ==============================
// configuration bus
// ==============================
`define CMAC_AXIL_ADDR_W 4
`define CMAC_AXIL_DATA_W 32

// register map, byte addresses
`define CMAC_REG_MODE    4'h0   // bit 0 = mode

`endif

/* src/cmac_cfg_pkg.sv */
// configuration side types; axi-lite channels travel as two packed structs
`include "cmac_mul_settings.svh"

package cmac_cfg_pkg;

  // stored in bit 0 of the mode register
  typedef enum logic {
    MODE_INT16 = 1'b0,
    MODE_INT8  = 1'b1
  } mul_mode_e;

  // master driven
  typedef struct packed {
    logic [`CMAC_AXIL_ADDR_W-1:0]   awaddr;
    logic                           awvalid;
    logic [`CMAC_AXIL_DATA_W-1:0]   wdata;
    logic [`CMAC_AXIL_DATA_W/8-1:0] wstrb;
    logic                           wvalid;
    logic                           bready;
    logic [`CMAC_AXIL_ADDR_W-1:0]   araddr;
    logic                           arvalid;
    logic                           rready;
  } axil_req_t;

  // slave driven
  typedef struct packed {
    logic                         awready;
    logic                         wready;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         arready;
    logic [`CMAC_AXIL_DATA_W-1:0] rdata;
    logic [1:0]                   rresp;
    logic                         rvalid;
  } axil_rsp_t;

  // write channel, WR_DATA = one of address/data taken, other pending
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } axil_wr_state_e;

endpackage

/* src/cmac_mul_pkg.sv */
// datapath types and the shared 3:2 compressor row
// the compressor works on full product width, narrower rows are zero extended
`include "cmac_mul_settings.svh"

package cmac_mul_pkg;
  import cmac_cfg_pkg::*;

  typedef logic [`CMAC_OP_W-1:0]  operand_t;
  typedef logic [`CMAC_LANES-1:0] nz_t;        // per-lane nonzero
  typedef logic [2:0]             booth_code_t;
  typedef logic [`CMAC_OP_W:0]    booth_sel_t; // selector plus inverted sign bit
  typedef logic [`CMAC_PP_W-1:0]  pp_row_t;
  typedef logic [`CMAC_RES_W-1:0] product_t;

  // input item as seen on the port, mode is added at sampling
  typedef struct packed {
    operand_t dat_a;
    operand_t dat_b;
    nz_t      nz_a;
    nz_t      nz_b;
  } mul_op_t;

  // sampled input item
  typedef struct packed {
    operand_t  dat_a;
    operand_t  dat_b;
    nz_t       nz_a;
    nz_t       nz_b;
    mul_mode_e mode;
  } mul_in_t;

  typedef struct packed {
    product_t  res;
    mul_mode_e mode;
  } mul_out_t;

  // stage-1 register, index 0 = low group, 1 = high group
  typedef struct packed {
    logic           valid;
    mul_mode_e      mode;
    nz_t            flags;
    pp_row_t [1:0]  sum;
    pp_row_t [1:0]  carry;
  } st1_t;

  // one row of full adders, carry already moved up one bit
  function automatic void csa(input product_t a, input product_t b, input product_t c,
                              output product_t s, output product_t co);
    s  = a ^ b ^ c;
    co = ((a & b) | (a & c) | (b & c)) << 1;
  endfunction

endpackage

/* src/cmac_cfg_regs.sv */
// axi4-lite slave, one write and one read in flight at a time
// only the mode register is mapped; all other offsets answer SLVERR
`timescale 1ns/10ps
`include "cmac_mul_settings.svh"

module cmac_cfg_regs import cmac_cfg_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  output mul_mode_e cfg_mode
);

localparam logic [1:0] RESP_OKAY   = 2'b00;
localparam logic [1:0] RESP_SLVERR = 2'b10;

axil_wr_state_e                wr_state;
logic                          awready;
logic                          wready;
logic                          bvalid;
logic [1:0]                    bresp;
logic                          arready;
logic                          rvalid;
logic [1:0]                    rresp;
logic [`CMAC_AXIL_DATA_W-1:0]  rdata;
logic [`CMAC_AXIL_DATA_W-1:0]  rd_word;
logic [`CMAC_AXIL_ADDR_W-1:0]  aw_addr_q;    // address taken ahead of data
logic                          w_bit_q;      // only bit 0 is stored anywhere
logic                          w_strb_q;
mul_mode_e                     mode_q;

logic                          aw_hs;
logic                          w_hs;
logic                          ar_hs;
logic                          wr_done;
logic [`CMAC_AXIL_ADDR_W-1:0]  wr_addr;
logic                          wr_bit;
logic                          wr_strb;
logic                          wr_hit;
logic                          rd_hit;

// ==============================
// handshakes and decode
// ==============================
assign aw_hs = axil_req.awvalid & awready;
assign w_hs  = axil_req.wvalid & wready;
assign ar_hs = axil_req.arvalid & arready;

// second half of the write arrives, or both together
assign wr_done = ((wr_state == WR_IDLE) & aw_hs & w_hs) |
                 ((wr_state == WR_DATA) & (aw_hs | w_hs));

assign wr_addr = aw_hs ? axil_req.awaddr   : aw_addr_q;  // fresh beat wins
assign wr_bit  = w_hs  ? axil_req.wdata[0] : w_bit_q;
assign wr_strb = w_hs  ? axil_req.wstrb[0] : w_strb_q;
assign wr_hit  = (wr_addr == `CMAC_REG_MODE);

assign rd_hit  = (axil_req.araddr == `CMAC_REG_MODE);
assign rd_word = rd_hit ? {{(`CMAC_AXIL_DATA_W-1){1'b0}}, mode_q} : '0;

// ==============================
// write fsm and mode register
// ==============================
always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    wr_state <= WR_IDLE;
    awready  <= 1'b0;
    wready   <= 1'b0;
    bvalid   <= 1'b0;
    mode_q   <= MODE_INT16;
  end else begin
    case (wr_state)
      WR_IDLE: begin
        if (aw_hs && w_hs) begin
          awready  <= 1'b0;
          wready   <= 1'b0;
          bvalid   <= 1'b1;
          wr_state <= WR_RESP;
        end else if (aw_hs) begin
          awready  <= 1'b0;         // wait for data
          wr_state <= WR_DATA;
        end else if (w_hs) begin
          wready   <= 1'b0;         // wait for address
          wr_state <= WR_DATA;
        end else begin
          awready  <= 1'b1;         // also the first rise after reset
          wready   <= 1'b1;
        end
      end
      WR_DATA: begin
        if (wr_done) begin
          awready  <= 1'b0;
          wready   <= 1'b0;
          bvalid   <= 1'b1;
          wr_state <= WR_RESP;
        end
      end
      default: begin                // WR_RESP, hold bvalid until bready
        if (axil_req.bready) begin
          bvalid   <= 1'b0;
          awready  <= 1'b1;
          wready   <= 1'b1;
          wr_state <= WR_IDLE;
        end
      end
    endcase
    if (wr_done && wr_hit && wr_strb) begin
      mode_q <= mul_mode_e'(wr_bit);
    end
  end
end

// ==============================
// read path
// ==============================
always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    arready <= 1'b0;
    rvalid  <= 1'b0;
  end else if (ar_hs) begin
    arready <= 1'b0;
    rvalid  <= 1'b1;
  end else if (rvalid && axil_req.rready) begin
    arready <= 1'b1;
    rvalid  <= 1'b0;
  end else if (!rvalid) begin
    arready <= 1'b1;
  end
end

// beat payloads and responses
always_ff @(posedge nvdla_core_clk) begin
  if (aw_hs) begin
    aw_addr_q <= axil_req.awaddr;
  end
  if (w_hs) begin
    w_bit_q  <= axil_req.wdata[0];
    w_strb_q <= axil_req.wstrb[0];
  end
  if (wr_done) begin
    bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
  end
  if (ar_hs) begin
    rdata <= rd_word;
    rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
  end
end

assign axil_rsp = '{awready: awready, wready: wready, bresp: bresp, bvalid: bvalid,
                    arready: arready, rdata: rdata, rresp: rresp, rvalid: rvalid};
assign cfg_mode = mode_q;

endmodule

/* src/cmac_booth_sel.sv */
// radix-4 booth selector; negative digits give ~x here and +1 through inv
// in 8-bit mode only src[7:0] is used and sel[16:9] stays clear
`timescale 1ns/10ps
`include "cmac_mul_settings.svh"

module cmac_booth_sel import cmac_mul_pkg::*; (
  input  booth_code_t code,
  input  logic        is_8bit,
  input  operand_t    src,
  output booth_sel_t  sel,
  output logic        inv
);

logic                  neg;    // digit < 0
logic                  one;    // |digit| == 1
logic                  two;    // |digit| == 2
booth_sel_t            mag16;
booth_sel_t            sel16;
logic [`CMAC_LANE_W:0] mag8;
logic [`CMAC_LANE_W:0] sel8;

// digit decode, 111 counts as +0
always_comb begin
  neg = code[2] & ~(code[1] & code[0]);
  one = code[1] ^ code[0];
  two = (code == 3'b011) | (code == 3'b100);
end

// magnitude with one bit of sign extension
always_comb begin
  mag16 = '0;
  mag8  = '0;
  if (one) begin
    mag16 = {src[`CMAC_OP_W-1], src};
    mag8  = {src[`CMAC_LANE_W-1], src[`CMAC_LANE_W-1:0]};
  end else if (two) begin
    mag16 = {src, 1'b0};                       // 2x, sign lands in top bit
    mag8  = {src[`CMAC_LANE_W-1:0], 1'b0};
  end
end

// Sign handling: one's complement for negative digits, then the top bit is
// inverted so every row carries a constant +2^16 (or +2^8) instead of a
// sign extension. The reduce stage takes that bias back out.
always_comb begin
  sel16 = neg ? ~mag16 : mag16;
  sel8  = neg ? ~mag8 : mag8;
  sel16[`CMAC_OP_W]   = ~sel16[`CMAC_OP_W];
  sel8[`CMAC_LANE_W]  = ~sel8[`CMAC_LANE_W];
end

assign sel = is_8bit ? booth_sel_t'(sel8) : sel16;
assign inv = neg;        // +1 of the two's complement, added in the next row

endmodule

/* src/cmac_pp_array.sv */
// stage 1: booth recoding, 8 selectors, two 5-row groups compressed to sum/carry
// mode is sampled with each input so items in flight keep their own mode
`timescale 1ns/10ps
`include "cmac_mul_settings.svh"

module cmac_pp_array import cmac_cfg_pkg::*; import cmac_mul_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  mul_mode_e cfg_mode,
  input  logic      in_valid,
  input  mul_op_t   in_data,
  output st1_t      st1
);

mul_in_t                           item;
logic                              is_int8;
logic [`CMAC_LANE_W:0]             code_lo;    // a[7:0] plus implicit 0
logic [`CMAC_LANE_W:0]             code_hi;
booth_code_t [`CMAC_BOOTH_GRP-1:0] code;
operand_t [1:0]                    src;        // per group multiplicand
booth_sel_t [`CMAC_BOOTH_GRP-1:0]  sel;
logic [`CMAC_BOOTH_GRP-1:0]        inv;
pp_row_t [1:0]                     grp_sum;
pp_row_t [1:0]                     grp_carry;

logic                              st1_valid;
mul_mode_e                         st1_mode;
nz_t                               st1_flags;
pp_row_t [1:0]                     st1_sum;
pp_row_t [1:0]                     st1_carry;

assign item = '{dat_a: in_data.dat_a, dat_b: in_data.dat_b, nz_a: in_data.nz_a,
                nz_b: in_data.nz_b, mode: cfg_mode};
assign is_int8 = (item.mode == MODE_INT8);

// ==============================
// booth recoding
// ==============================
assign code_lo = {item.dat_a[`CMAC_LANE_W-1:0], 1'b0};
assign code_hi = is_int8 ? {item.dat_a[`CMAC_OP_W-1:`CMAC_LANE_W], 1'b0}   // fresh lane
                         : item.dat_a[`CMAC_OP_W-1:`CMAC_LANE_W-1];         // overlap bit 7

always_comb begin
  for (int i = 0; i < `CMAC_BOOTH_GRP / 2; i++) begin
    code[i]                     = code_lo[2*i +: 3];
    code[i + `CMAC_BOOTH_GRP/2] = code_hi[2*i +: 3];
  end
end

// int8: low group takes b[7:0], high group b[15:8]
assign src[0] = is_int8 ? operand_t'(item.dat_b[`CMAC_LANE_W-1:0]) : item.dat_b;
assign src[1] = is_int8 ? operand_t'(item.dat_b[`CMAC_OP_W-1:`CMAC_LANE_W]) : item.dat_b;

for (genvar k = 0; k < `CMAC_BOOTH_GRP; k++) begin : g_booth
  cmac_booth_sel u_sel (
    .code    (code[k]),
    .is_8bit (is_int8),
    .src     (src[k / 4]),
    .sel     (sel[k]),
    .inv     (inv[k])
  );
end

// ==============================
// row alignment and level 1
// ==============================
for (genvar g = 0; g < 2; g++) begin : g_grp
  pp_row_t [4:0] row;
  product_t      s0, c0, s1, c1, s2, c2;

  always_comb begin
    row[0] = {7'b0, sel[4*g]};
    row[1] = {5'b0, sel[4*g+1], 1'b0, inv[4*g]};            // inv of previous row
    row[2] = {3'b0, sel[4*g+2], 1'b0, inv[4*g+1], 2'b0};
    row[3] = {1'b0, sel[4*g+3], 1'b0, inv[4*g+2], 4'b0};
    row[4] = {17'b0, inv[4*g+3], 6'b0};                     // last +1 alone
    csa(product_t'(row[0]), product_t'(row[1]), product_t'(row[2]), s0, c0);
    csa(s0, c0, product_t'(row[3]), s1, c1);
    csa(s1, c1, product_t'(row[4]), s2, c2);
  end

  // group total stays below 2^24 so nothing is lost above bit 23
  assign grp_sum[g]   = s2[`CMAC_PP_W-1:0];
  assign grp_carry[g] = c2[`CMAC_PP_W-1:0];
end

// ==============================
// stage-1 register
// ==============================
always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    st1_valid <= 1'b0;
  end else begin
    st1_valid <= in_valid;
  end
end

always_ff @(posedge nvdla_core_clk) begin
  if (in_valid) begin
    st1_mode  <= item.mode;
    st1_flags <= item.nz_a & item.nz_b;   // lane live only if both sides nonzero
    st1_sum   <= grp_sum;
    st1_carry <= grp_carry;
  end
end

assign st1 = '{valid: st1_valid, mode: st1_mode, flags: st1_flags,
               sum: st1_sum, carry: st1_carry};

endmodule

/* src/cmac_pp_reduce.sv */
// stage 2: level-2 compression, final add with bias removal, lane zeroing
// result is a plain two's complement product, or two 16-bit lane products
`timescale 1ns/10ps
`include "cmac_mul_settings.svh"

module cmac_pp_reduce import cmac_cfg_pkg::*; import cmac_mul_pkg::*; (
  input  logic     nvdla_core_clk,
  input  logic     nvdla_core_rstn,
  input  st1_t     st1,
  output logic     out_valid,
  output mul_out_t out_data
);

localparam int HALF_W = `CMAC_RES_W / `CMAC_LANES;

// every row carries +2^16 (int8: +2^8) at weights 4^0..4^3 of its group
localparam product_t          INT16_BIAS = 32'h5555_0000;  // 0x550000 + (0x550000 << 8)
localparam logic [HALF_W-1:0] INT8_BIAS  = 16'h5500;

product_t [3:0]                    l2_row;
product_t                          s0, c0, s1, c1;
product_t                          res16;
logic [`CMAC_LANES-1:0][HALF_W-1:0] lane;
product_t                          res_sel;

// ==============================
// int16 path
// ==============================
always_comb begin
  l2_row[0] = product_t'(st1.sum[0]);
  l2_row[1] = product_t'(st1.carry[0]);
  l2_row[2] = {st1.sum[1], 8'b0};          // high group weighs 2^8
  l2_row[3] = {st1.carry[1], 8'b0};
  csa(l2_row[0], l2_row[1], l2_row[2], s0, c0);
  csa(s0, c0, l2_row[3], s1, c1);
  res16 = s1 + c1 - INT16_BIAS;            // final cpa
end

// int8 path, each group pair fits 16 bits
always_comb begin
  for (int l = 0; l < `CMAC_LANES; l++) begin
    lane[l] = st1.sum[l][HALF_W-1:0] + st1.carry[l][HALF_W-1:0] - INT8_BIAS;
  end
end

// mode select and zero skip
always_comb begin
  if (st1.mode == MODE_INT8) begin
    for (int l = 0; l < `CMAC_LANES; l++) begin
      res_sel[l*HALF_W +: HALF_W] = st1.flags[l] ? lane[l] : '0;
    end
  end else begin
    res_sel = (&st1.flags) ? res16 : '0;   // int16 needs both lanes flagged
  end
end

// ==============================
// output register
// ==============================
always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
  if (!nvdla_core_rstn) begin
    out_valid <= 1'b0;
  end else begin
    out_valid <= st1.valid;
  end
end

always_ff @(posedge nvdla_core_clk) begin
  if (st1.valid) begin
    out_data <= '{res: res_sel, mode: st1.mode};
  end
end

endmodule

/* src/cmac_mul_top.sv */
// booth multiplier slice, 2-cycle latency, no back-pressure on the data stream
// mode register writes only affect inputs taken after the write response
`timescale 1ns/10ps

module cmac_mul_top import cmac_cfg_pkg::*; import cmac_mul_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  // configuration
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  // data stream
  input  logic      in_valid,
  input  mul_op_t   in_data,
  output logic      out_valid,
  output mul_out_t  out_data
);

mul_mode_e cfg_mode;   // sampled per item in stage 1
st1_t      st1;

cmac_cfg_regs u_cfg_regs (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .axil_req        (axil_req),
  .axil_rsp        (axil_rsp),
  .cfg_mode        (cfg_mode)
);

// stage 1
cmac_pp_array u_pp_array (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .cfg_mode        (cfg_mode),
  .in_valid        (in_valid),
  .in_data         (in_data),
  .st1             (st1)
);

// stage 2
cmac_pp_reduce u_pp_reduce (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .st1             (st1),
  .out_valid       (out_valid),
  .out_data        (out_data)
);

endmodule

/* bench/cmac_mul_checker.sv */
// bound to cmac_mul_top; cfg_mode is the internal mode seen by stage 1
// all properties are off while reset is low
`timescale 1ns/10ps

module cmac_mul_checker import cmac_cfg_pkg::*; import cmac_mul_pkg::*; (
  input logic      nvdla_core_clk,
  input logic      nvdla_core_rstn,
  input axil_req_t axil_req,
  input axil_rsp_t axil_rsp,
  input logic      in_valid,
  input mul_op_t   in_data,
  input logic      out_valid,
  input mul_mode_e cfg_mode
);

// ==============================
// stream
// ==============================
a_latency: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
  out_valid == $past(in_valid, 2))
  else $error("out_valid does not follow in_valid by two cycles");

// int16 flags come in equal pairs per operand
a_int16_nz: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
  (in_valid && cfg_mode == MODE_INT16) |->
    (in_data.nz_a[0] == in_data.nz_a[1]) && (in_data.nz_b[0] == in_data.nz_b[1]))
  else $error("int16 input with unequal nz bits in an operand");

// ==============================
// axi-lite responses
// ==============================
a_bvalid_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
  (axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid)
  else $error("bvalid dropped before bready");

a_rvalid_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
  (axil_rsp.rvalid && !axil_req.rready) |=> axil_rsp.rvalid)
  else $error("rvalid dropped before rready");

endmodule

bind cmac_mul_top cmac_mul_checker u_checker (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .axil_req        (axil_req),
  .axil_rsp        (axil_rsp),
  .in_valid        (in_valid),
  .in_data         (in_data),
  .out_valid       (out_valid),
  .cfg_mode        (cfg_mode)
);

/* bench/cmac_mul_tb.sv */
// self-checking testbench, expected items come from a plain signed multiply model
// mode writes go out over axi-lite between runs of back-to-back inputs
`timescale 1ns/10ps
`include "cmac_mul_settings.svh"

module cmac_mul_tb import cmac_cfg_pkg::*; import cmac_mul_pkg::*; ();

localparam int          NUM_FIXED   = 12;
localparam int          NUM_RAND    = 28;
localparam int          NUM_ROWS    = NUM_FIXED + NUM_RAND;
localparam int          WAIT_MAX    = 64;           // cycles per handshake wait
localparam logic [1:0]  RESP_OKAY   = 2'b00;
localparam logic [1:0]  RESP_SLVERR = 2'b10;
localparam logic [31:0] LFSR_POLY   = 32'h8020_0003; // x^32+x^22+x^2+x+1

// one stimulus row
typedef struct packed {
  mul_mode_e mode;
  operand_t  a;
  operand_t  b;
  nz_t       nz_a;
  nz_t       nz_b;
} stim_row_t;

logic        nvdla_core_clk;
logic        nvdla_core_rstn;
axil_req_t   axil_req;
axil_rsp_t   axil_rsp;
logic        in_valid;
mul_op_t     in_data;
logic        out_valid;
mul_out_t    out_data;

stim_row_t   rows [NUM_ROWS];
mul_out_t    exp_q [$];      // expected items in issue order
logic [31:0] lfsr;
mul_mode_e   cur_mode;       // mode register as last written
logic [1:0]  resp;
logic [31:0] rd_data;

cmac_mul_top u_dut (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .axil_req        (axil_req),
  .axil_rsp        (axil_rsp),
  .in_valid        (in_valid),
  .in_data         (in_data),
  .out_valid       (out_valid),
  .out_data        (out_data)
);

initial begin
  nvdla_core_clk = 1'b0;
  forever #50 nvdla_core_clk = ~nvdla_core_clk;   // 100 ns period
end

// ==============================
// error reporting and compares
// ==============================
task automatic abort_run(input string why);
  $display("%s", why);
  $display("Testbench failed");
  $fatal(1, "run stopped at first error");
endtask

task automatic check_product(input string name, input product_t got, input product_t exp);
  if (got !== exp) begin
    abort_run($sformatf("Mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                        $time, name, got, exp));
  end
endtask

task automatic check_mode(input string name, input mul_mode_e got, input mul_mode_e exp);
  if (got !== exp) begin
    abort_run($sformatf("Mismatch at time %0t: %s got %s expected %s",
                        $time, name, got.name(), exp.name()));
  end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("Mismatch at time %0t: %s got %b expected %b", $time, name, got, exp));
  end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("Mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                        $time, name, got, exp));
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("Mismatch at time %0t: %s got %b expected %b", $time, name, got, exp));
  end
endtask

// ==============================
// random source and model
// ==============================
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
endfunction

task automatic take_bits(input int n, output logic [31:0] val);
  val = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr_next(lfsr);               // one step per bit
    val  = {val[30:0], lfsr[0]};
  end
endtask

// int16 needs all four flags, int8 lanes need their own pair
function automatic mul_out_t model_out(input stim_row_t r);
  mul_out_t          o;
  logic signed [31:0] wa;
  logic signed [31:0] wb;
  logic signed [15:0] xa;
  logic signed [15:0] xb;
  o.mode = r.mode;
  o.res  = '0;
  if (r.mode == MODE_INT16) begin
    wa = 32'($signed(r.a));
    wb = 32'($signed(r.b));
    if ((&r.nz_a) && (&r.nz_b)) o.res = wa * wb;
  end else begin
    for (int l = 0; l < 2; l++) begin
      xa = 16'($signed(r.a[8*l +: 8]));
      xb = 16'($signed(r.b[8*l +: 8]));
      if (r.nz_a[l] && r.nz_b[l]) o.res[16*l +: 16] = xa * xb;
    end
  end
  return o;
endfunction

task automatic fill_table();
  logic [31:0] bits;
  mul_mode_e   run_mode;
  rows[0]  = '{MODE_INT16, 16'h8000, 16'h8000, 2'b11, 2'b11};
  rows[1]  = '{MODE_INT16, 16'hffff, 16'hffff, 2'b11, 2'b11};
  rows[2]  = '{MODE_INT16, 16'h7fff, 16'h8000, 2'b11, 2'b11};
  rows[3]  = '{MODE_INT16, 16'h1234, 16'hfffe, 2'b11, 2'b11};
  rows[4]  = '{MODE_INT16, 16'h1234, 16'h5678, 2'b00, 2'b11};   // zero skip
  rows[5]  = '{MODE_INT8,  16'h7f80, 16'h807f, 2'b11, 2'b11};   // 0x7f * 0x80 per lane
  rows[6]  = '{MODE_INT8,  16'h8080, 16'h8080, 2'b11, 2'b11};
  rows[7]  = '{MODE_INT8,  16'hff01, 16'h02fe, 2'b11, 2'b11};
  rows[8]  = '{MODE_INT8,  16'h1234, 16'h5678, 2'b01, 2'b11};   // high lane off
  rows[9]  = '{MODE_INT8,  16'h9abc, 16'hdef0, 2'b11, 2'b10};   // low lane off
  rows[10] = '{MODE_INT16, 16'h00ff, 16'h0100, 2'b11, 2'b11};   // overlap at bit 7
  rows[11] = '{MODE_INT16, 16'hc3a5, 16'h5a3c, 2'b11, 2'b11};
  run_mode = MODE_INT16;
  for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
    if ((i % 4) == 0) begin
      take_bits(1, bits);
      run_mode = mul_mode_e'(bits[0]);    // runs of four share a mode
    end
    rows[i].mode = run_mode;
    take_bits(16, bits);
    rows[i].a = bits[15:0];
    take_bits(16, bits);
    rows[i].b = bits[15:0];
    take_bits(2, bits);
    rows[i].nz_a = (run_mode == MODE_INT16) ? {2{|bits[1:0]}} : bits[1:0];
    take_bits(2, bits);
    rows[i].nz_b = (run_mode == MODE_INT16) ? {2{|bits[1:0]}} : bits[1:0];
  end
endtask

// ==============================
// axi-lite master, called at a rising edge
// ==============================
task automatic axil_write(input logic [`CMAC_AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                          output logic [1:0] bresp);
  logic aw_open;
  logic w_open;
  int   waited;
  aw_open = 1'b1;
  w_open  = 1'b1;
  waited  = 0;
  axil_req.awaddr  <= addr;
  axil_req.awvalid <= 1'b1;
  axil_req.wdata   <= data;
  axil_req.wstrb   <= '1;
  axil_req.wvalid  <= 1'b1;
  axil_req.bready  <= 1'b0;               // raised only once bvalid is up
  while (aw_open || w_open) begin
    @(posedge nvdla_core_clk);
    if (aw_open && axil_rsp.awready) begin
      aw_open = 1'b0;
      axil_req.awvalid <= 1'b0;
    end
    if (w_open && axil_rsp.wready) begin
      w_open = 1'b0;
      axil_req.wvalid <= 1'b0;
    end
    waited++;
    if (waited > WAIT_MAX) abort_run("write address or data was never accepted");
  end
  waited = 0;
  do begin
    @(posedge nvdla_core_clk);
    waited++;
    if (waited > WAIT_MAX) abort_run("write response never arrived");
  end while (!axil_rsp.bvalid);
  bresp = axil_rsp.bresp;
  axil_req.bready <= 1'b1;
  @(posedge nvdla_core_clk);              // response taken here
  axil_req.bready <= 1'b0;
endtask

task automatic axil_read(input logic [`CMAC_AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
                         output logic [1:0] rresp);
  int waited;
  waited = 0;
  axil_req.araddr  <= addr;
  axil_req.arvalid <= 1'b1;
  axil_req.rready  <= 1'b0;               // raised only once rvalid is up
  do begin
    @(posedge nvdla_core_clk);
    waited++;
    if (waited > WAIT_MAX) abort_run("read address was never accepted");
  end while (!axil_rsp.arready);
  axil_req.arvalid <= 1'b0;
  waited = 0;
  do begin
    @(posedge nvdla_core_clk);
    waited++;
    if (waited > WAIT_MAX) abort_run("read data never arrived");
  end while (!axil_rsp.rvalid);
  data  = axil_rsp.rdata;
  rresp = axil_rsp.rresp;
  axil_req.rready <= 1'b1;
  @(posedge nvdla_core_clk);              // data beat taken here
  axil_req.rready <= 1'b0;
endtask

// output side, registered values read at the edge
always @(posedge nvdla_core_clk) begin : out_monitor
  mul_out_t exp_item;
  if (nvdla_core_rstn && out_valid) begin
    if (exp_q.size() == 0) begin
      abort_run("out_valid high with no input outstanding");
    end else begin
      exp_item = exp_q.pop_front();
      check_product("out_data.res", out_data.res, exp_item.res);
      check_mode("out_data.mode", out_data.mode, exp_item.mode);
    end
  end
end

// ==============================
// main sequence
// ==============================
initial begin : stimulus
  int waited;
  nvdla_core_rstn <= 1'b0;
  in_valid        <= 1'b0;
  in_data         <= '0;
  axil_req        <= '0;
  lfsr     = 32'h4a8c;
  cur_mode = MODE_INT16;
  fill_table();
  repeat (16) @(posedge nvdla_core_clk);
  nvdla_core_rstn <= 1'b1;

  // reset state
  @(posedge nvdla_core_clk);
  check_flag("out_valid", out_valid, 1'b0);
  axil_read(`CMAC_REG_MODE, rd_data, resp);
  check_resp("rresp", resp, RESP_OKAY);
  check_word("rdata", rd_data, {31'b0, MODE_INT16});

  // table, a mode write starts right behind the last item of a run
  for (int i = 0; i < NUM_ROWS; i++) begin
    @(posedge nvdla_core_clk);
    in_valid <= 1'b1;
    in_data  <= '{dat_a: rows[i].a, dat_b: rows[i].b, nz_a: rows[i].nz_a, nz_b: rows[i].nz_b};
    exp_q.push_back(model_out(rows[i]));
    if ((i + 1 < NUM_ROWS) && (rows[i+1].mode != cur_mode)) begin
      fork
        axil_write(`CMAC_REG_MODE, {31'b0, rows[i+1].mode}, resp);
        begin
          @(posedge nvdla_core_clk);
          in_valid <= 1'b0;               // row i taken with the old mode
        end
      join
      check_resp("bresp", resp, RESP_OKAY);
      cur_mode = rows[i+1].mode;
    end
  end
  @(posedge nvdla_core_clk);
  in_valid <= 1'b0;

  waited = 0;
  while (exp_q.size() != 0) begin
    @(posedge nvdla_core_clk);
    waited++;
    if (waited > WAIT_MAX) abort_run("outputs stopped before all items arrived");
  end

  // unmapped offsets
  axil_write(4'h4, {31'b0, ~cur_mode}, resp);
  check_resp("bresp", resp, RESP_SLVERR);
  axil_read(4'h8, rd_data, resp);
  check_resp("rresp", resp, RESP_SLVERR);
  check_word("rdata", rd_data, 32'h0);
  axil_read(`CMAC_REG_MODE, rd_data, resp);
  check_resp("rresp", resp, RESP_OKAY);
  check_word("rdata", rd_data, {31'b0, cur_mode});   // mode untouched

  @(posedge nvdla_core_clk);
  $display("Testbench passed");
  $finish;
end

endmodule

/* compile.f */
+incdir+src
src/cmac_cfg_pkg.sv
src/cmac_mul_pkg.sv
src/cmac_cfg_regs.sv
src/cmac_booth_sel.sv
src/cmac_pp_array.sv
src/cmac_pp_reduce.sv
src/cmac_mul_top.sv
bench/cmac_mul_checker.sv
bench/cmac_mul_tb.sv

/* Makefile */
# Verilator build and run of the multiplier slice testbench
# the run fails through the simulator exit status

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= cmac_mul_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
